// File: uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line rate set up for the 25 MHz system clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define UART_CLOCK_RATE 25_000_000
`define UART_BAUD 1_562_500

// integer division, the two rates must divide evenly
`define UART_CLKS_PER_BIT (`UART_CLOCK_RATE / `UART_BAUD)

// the sampler waits this long after the start edge before it checks the line again
`define UART_HALF_BIT (`UART_CLKS_PER_BIT / 2)

// wide enough to hold a full bit time
`define UART_CNT_W ($clog2(`UART_CLKS_PER_BIT + 1))

// frame layout, start bit and stop bit fixed
//   start | d0 .. d7 | stop
// the receive side numbers the samples 0 to 8, where 8 is the stop sample

`endif

// File: uart_pkg.sv
package uart_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // receive sampler
  typedef enum logic [1:0] {
    rx_hunt,        // waiting for the line to fall
    rx_start_half,  // half a bit into a possible start bit
    rx_bits         // one strobe per whole bit time
  } rx_state_e;

  // transmit serializer
  typedef enum logic {
    tx_idle,
    tx_send
  } tx_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one mid-bit sample, sampler to framer
  typedef struct packed {
    logic       level;
    logic [3:0] index;  // 0 to 7 data bits, 8 the stop bit
  } rx_sample_t;

  // one received byte, framer to host
  typedef struct packed {
    logic [7:0] data;
    logic       frame_err;  // stop bit was sampled low
  } rx_byte_t;

endpackage

// File: uart_rx_sampler.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx_sampler (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 serial_i,
  output uart_pkg::rx_sample_t sample_o,
  output logic                 sample_valid_o
);
  import uart_pkg::*;

  rx_state_e              state;
  logic [`UART_CNT_W-1:0] bit_cnt;
  logic [3:0]             bit_idx;
  logic                   serial_meta;
  logic                   serial_sync;
  logic                   half_done;
  logic                   bit_done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line synchronizer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // both flops come up at the idle level so reset cannot look like a start
  always_ff @(posedge clk) begin
    if (reset) begin
      serial_meta <= 1'b1;
      serial_sync <= 1'b1;
    end else begin
      serial_meta <= serial_i;
      serial_sync <= serial_meta;
    end
  end

  assign half_done = (bit_cnt == `UART_CNT_W'(`UART_HALF_BIT - 1));
  assign bit_done  = (bit_cnt == `UART_CNT_W'(`UART_CLKS_PER_BIT - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // start hunt and bit timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= rx_hunt;
      bit_cnt        <= '0;
      bit_idx        <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= 1'b0;
      case (state)
        rx_hunt: begin
          bit_cnt <= '0;
          if (!serial_sync) begin
            state <= rx_start_half;
          end
        end
        rx_start_half: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (half_done) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            // a line back high by now was only a glitch
            state   <= serial_sync ? rx_hunt : rx_bits;
          end
        end
        rx_bits: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_done) begin
            bit_cnt        <= '0;
            bit_idx        <= bit_idx + 1'b1;
            sample_valid_o <= 1'b1;
            if (bit_idx == 4'd8) begin
              state <= rx_hunt;  // stop sampled, next start can already be seen
            end
          end
        end
        default: state <= rx_hunt;
      endcase
    end
  end

  // sample payload, only meaningful with the strobe
  always_ff @(posedge clk) begin
    if (state == rx_bits && bit_done) begin
      sample_o.level <= serial_sync;
      sample_o.index <= bit_idx;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_index_range: assert property (@(posedge clk) disable iff (reset)
    sample_valid_o |-> sample_o.index <= 4'd8);

  // a strobe seen back in hunt can only be the stop sample, and the stop sample always ends the frame
  a_no_strobe_in_hunt: assert property (@(posedge clk) disable iff (reset)
    sample_valid_o |-> ((state == rx_hunt) == (sample_o.index == 4'd8)));

endmodule

// File: uart_rx_framer.sv
`timescale 1ns/1ps

module uart_rx_framer (
  input  logic                 clk,
  input  logic                 reset,
  input  uart_pkg::rx_sample_t sample_i,
  input  logic                 sample_valid_i,
  output uart_pkg::rx_byte_t   rx_byte_o,
  output logic                 rx_valid_o
);
  import uart_pkg::*;

  logic [7:0] data_q;
  logic [3:0] expect_idx;
  logic       data_strobe;
  logic       stop_strobe;

  // indexes 0 to 7 carry data, 8 is the stop sample
  assign data_strobe = sample_valid_i && !sample_i.index[3];
  assign stop_strobe = sample_valid_i && (sample_i.index == 4'd8);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // byte assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // LSB arrives first, each sample lands at its own bit position
  always_ff @(posedge clk) begin
    if (data_strobe) begin
      data_q[sample_i.index[2:0]] <= sample_i.level;
    end
  end

  // published byte holds until the next stop sample
  always_ff @(posedge clk) begin
    if (stop_strobe) begin
      rx_byte_o.data      <= data_q;
      rx_byte_o.frame_err <= !sample_i.level;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // strobe and sample order
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_valid_o <= 1'b0;
      expect_idx <= '0;
    end else begin
      rx_valid_o <= stop_strobe;  // one cycle behind the stop sample
      if (sample_valid_i) begin
        expect_idx <= stop_strobe ? 4'd0 : sample_i.index + 1'b1;
      end
    end
  end

  // a frame must come in as 0, 1, .. 8 with nothing skipped
  a_index_order: assert property (@(posedge clk) disable iff (reset)
    sample_valid_i |-> sample_i.index == expect_idx);

endmodule

// File: uart_tx_serializer.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx_serializer (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] tx_data_i,
  input  logic       tx_valid_i,
  output logic       serial_o,
  output logic       tx_busy_o
);
  import uart_pkg::*;

  tx_state_e              state;
  logic [`UART_CNT_W-1:0] bit_cnt;
  logic [3:0]             bit_idx;
  logic [8:0]             shift_q;
  logic                   serial_q;
  logic                   start;
  logic                   bit_done;

  assign start    = (state == tx_idle) && tx_valid_i;
  assign bit_done = (bit_cnt == `UART_CNT_W'(`UART_CLKS_PER_BIT - 1));

  // the host sees busy on the very cycle it strobes
  assign tx_busy_o = tx_valid_i | (state == tx_send);
  assign serial_o  = serial_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // bit_idx 0 is the start bit, 1 to 8 the data and 9 the stop bit
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= tx_idle;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      serial_q <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          serial_q <= 1'b1;
          if (tx_valid_i) begin
            state    <= tx_send;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            serial_q <= 1'b0;  // start bit goes out with the latching edge
          end
        end
        tx_send: begin
          if (bit_done) begin
            bit_cnt <= '0;
            if (bit_idx == 4'd9) begin
              state <= tx_idle;  // stop bit has had its full time
            end else begin
              bit_idx  <= bit_idx + 1'b1;
              serial_q <= shift_q[0];
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data shifter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the stop bit rides above the data and reaches bit 0 after eight shifts
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= {1'b1, tx_data_i};
    end else if (state == tx_send && bit_done) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // holds across the return from send, where the stop bit must still be on the line
  a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
    state == tx_idle |-> serial_o);

  a_no_strobe_when_busy: assert property (@(posedge clk) disable iff (reset)
    tx_valid_i |-> state == tx_idle);

endmodule

// File: uart_top.sv
`timescale 1ns/1ps

module uart_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       serial_i,
  output logic       serial_o,
  input  logic [7:0] tx_data_i,
  input  logic       tx_valid_i,
  output logic       tx_busy_o,
  output logic [7:0] rx_data_o,
  output logic       rx_valid_o,
  output logic       rx_frame_err_o
);
  import uart_pkg::*;

  rx_sample_t sample;
  logic       sample_valid;
  rx_byte_t   rx_byte;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive path, sampler then framer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  uart_rx_sampler u_rx_sampler (
    .clk            (clk),
    .reset          (reset),
    .serial_i       (serial_i),
    .sample_o       (sample),
    .sample_valid_o (sample_valid)
  );

  uart_rx_framer u_rx_framer (
    .clk            (clk),
    .reset          (reset),
    .sample_i       (sample),
    .sample_valid_i (sample_valid),
    .rx_byte_o      (rx_byte),
    .rx_valid_o     (rx_valid_o)
  );

  assign rx_data_o      = rx_byte.data;
  assign rx_frame_err_o = rx_byte.frame_err;

  // transmit path
  uart_tx_serializer u_tx_serializer (
    .clk        (clk),
    .reset      (reset),
    .tx_data_i  (tx_data_i),
    .tx_valid_i (tx_valid_i),
    .serial_o   (serial_o),
    .tx_busy_o  (tx_busy_o)
  );

endmodule

// File: tb_uart_line.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_line (
  input  logic       clk,
  input  logic       rx_valid_i,
  output logic       serial_o,
  output logic       exp_valid_o,
  output logic [7:0] exp_data_o,
  output logic       exp_err_o,
  output int         exp_count_o
);

  logic [8:0] exp_q[$];  // {frame_err, data} of every frame the receiver still owes
  logic       pop_pending;

  function automatic void refresh_head();
    exp_count_o = exp_q.size();
    exp_valid_o = (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      {exp_err_o, exp_data_o} = exp_q[0];
    end
  endfunction

  initial begin
    serial_o   = 1'b1;
    exp_data_o = '0;
    exp_err_o  = 1'b0;
    refresh_head();
  end

  // the checks sample rx_valid one edge after it rises, the head goes on the falling edge after that
  always @(posedge clk) begin
    pop_pending <= rx_valid_i;
  end

  always @(negedge clk) begin
    if (pop_pending && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  // one frame at one bit per bit time, start then d0 to d7 then stop
  task automatic send_frame(input logic [7:0] data, input logic good_stop);
    logic [9:0] frame;
    int         i;
    frame = {good_stop, data, 1'b0};
    exp_q.push_back({~good_stop, data});
    refresh_head();
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      serial_o = frame[i];
      repeat (`UART_CLKS_PER_BIT - 1) @(negedge clk);
    end
    if (!good_stop) begin
      @(negedge clk);
      serial_o = 1'b1;  // an idle bit, the next start needs a falling edge
      repeat (`UART_CLKS_PER_BIT - 1) @(negedge clk);
    end
  endtask

  task automatic glitch(input int cycles);
    @(negedge clk);
    serial_o = 1'b0;
    repeat (cycles) @(negedge clk);
    serial_o = 1'b1;
    // give the sampler time to drop the false start and return to hunt
    repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);
  endtask

endmodule

// File: tb_uart_top.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_top;

  localparam int     frame_cycles = 10 * `UART_CLKS_PER_BIT;
  localparam int     num_tests    = 6;
  localparam longint watchdog_ns  = (longint'(num_tests) * 60 * frame_cycles + 4) * 40;

  logic       clk = 1'b0;
  logic       reset;
  logic       serial_rx;
  logic       serial_tx;
  logic [7:0] tx_data;
  logic       tx_valid;
  logic       tx_busy;
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_frame_err;
  logic       exp_valid;
  logic [7:0] exp_data;
  logic       exp_err;
  int         exp_count;
  logic       idle_check;
  int         errors = 0;
  int         errors_at_start = 0;
  int         passed = 0;
  int         failed = 0;
  int         tx_sent = 0;
  int         tx_checked = 0;

  always #20 clk = ~clk;

  uart_top u_dut (
    .clk            (clk),
    .reset          (reset),
    .serial_i       (serial_rx),
    .serial_o       (serial_tx),
    .tx_data_i      (tx_data),
    .tx_valid_i     (tx_valid),
    .tx_busy_o      (tx_busy),
    .rx_data_o      (rx_data),
    .rx_valid_o     (rx_valid),
    .rx_frame_err_o (rx_frame_err)
  );

  tb_uart_line u_line (
    .clk         (clk),
    .rx_valid_i  (rx_valid),
    .serial_o    (serial_rx),
    .exp_valid_o (exp_valid),
    .exp_data_o  (exp_data),
    .exp_err_o   (exp_err),
    .exp_count_o (exp_count)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive and idle checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_idle: assert property (@(posedge clk) disable iff (reset)
    idle_check |-> serial_tx && !tx_busy && !rx_valid)
    else begin
      errors++;
      $display("error: idle serial_o/tx_busy_o/rx_valid_o expected 1/0/0 got %h/%h/%h",
               serial_tx, tx_busy, rx_valid);
    end

  a_rx_owed: assert property (@(posedge clk) disable iff (reset) rx_valid |-> exp_valid)
    else begin
      errors++;
      $display("rx_valid_o pulsed although no frame was outstanding");
    end

  a_rx_data: assert property (@(posedge clk) disable iff (reset)
    rx_valid && exp_valid |-> rx_data == exp_data)
    else begin
      errors++;
      $display("error: rx_data_o expected %h got %h", exp_data, rx_data);
    end

  a_rx_err: assert property (@(posedge clk) disable iff (reset)
    rx_valid && exp_valid |-> rx_frame_err == exp_err)
    else begin
      errors++;
      $display("error: rx_frame_err_o expected %h got %h", exp_err, rx_frame_err);
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transmit monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // busy from the strobe edge through ten bit times, then low unless a new strobe is there
  always begin : busy_monitor
    @(posedge clk);
    while (!reset && tx_valid) begin
      repeat (frame_cycles + 1) begin
        assert (tx_busy) else begin
          errors++;
          $display("error: tx_busy_o expected 1 got %h", tx_busy);
        end
        @(posedge clk);
      end
      assert (!tx_busy || tx_valid) else begin
        errors++;
        $display("error: tx_busy_o expected 0 got %h", tx_busy);
      end
    end
  end

  always begin : line_monitor
    logic [7:0] sent;
    logic [7:0] rebuilt;
    int         i;
    @(posedge clk);
    if (!reset && tx_valid) begin
      sent = tx_data;
      @(posedge clk);
      while (serial_tx) @(posedge clk);
      repeat (`UART_HALF_BIT) @(posedge clk);  // centre of the start bit
      assert (!serial_tx) else begin
        errors++;
        $display("error: serial_o start bit expected 0 got %h", serial_tx);
      end
      for (i = 0; i < 8; i++) begin
        repeat (`UART_CLKS_PER_BIT) @(posedge clk);
        rebuilt[i] = serial_tx;
      end
      repeat (`UART_CLKS_PER_BIT) @(posedge clk);
      assert (serial_tx) else begin
        errors++;
        $display("error: serial_o stop bit expected 1 got %h", serial_tx);
      end
      assert (rebuilt == sent) else begin
        errors++;
        $display("error: serial_o byte expected %h got %h", sent, rebuilt);
      end
      tx_checked++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic transmit_byte(input logic [7:0] data);
    @(negedge clk);
    while (tx_busy) @(negedge clk);
    tx_data  = data;
    tx_valid = 1'b1;
    tx_sent++;
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  task automatic wait_rx_drained();
    int waited;
    waited = 0;
    @(posedge clk);
    while (exp_count != 0 && waited < 2 * frame_cycles) begin
      @(posedge clk);
      waited++;
    end
    assert (exp_count == 0) else begin
      errors++;
      $display("receiver did not deliver %0d expected byte(s) in time", exp_count);
    end
  endtask

  task automatic wait_tx_idle();
    @(negedge clk);
    while (tx_busy) @(negedge clk);
    repeat (2) @(negedge clk);
    assert (tx_checked == tx_sent) else begin
      errors++;
      $display("only %0d of %0d transmitted frames were seen on the line", tx_checked, tx_sent);
    end
  endtask

  task automatic close_test(input string name);
    if (errors == errors_at_start) begin
      passed++;
      $display("test %s: no errors", name);
    end else begin
      failed++;
      $display("test %s: %0d error(s)", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin : stimulus
    int n;
    int k;
    void'($urandom(32'he88a_73d5));
    reset      = 1'b1;
    tx_data    = '0;
    tx_valid   = 1'b0;
    idle_check = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    idle_check = 1'b1;
    repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);
    idle_check = 1'b0;
    close_test("reset idle");

    u_line.send_frame(8'h00, 1'b1);
    u_line.send_frame(8'hff, 1'b1);
    u_line.send_frame(8'ha5, 1'b1);
    for (n = 0; n < 20; n++) u_line.send_frame(8'($urandom()), 1'b1);
    wait_rx_drained();
    close_test("receive bytes");

    u_line.send_frame(8'h3c, 1'b0);  // stop bit held low
    u_line.send_frame(8'hc3, 1'b1);
    wait_rx_drained();
    close_test("framing error");

    u_line.glitch(3);
    u_line.send_frame(8'h5a, 1'b1);
    wait_rx_drained();
    close_test("glitch rejection");

    for (n = 0; n < 8; n++) transmit_byte(8'($urandom()));
    wait_tx_idle();
    close_test("transmit frame");

    fork
      for (n = 0; n < 10; n++) transmit_byte(8'($urandom()));
      for (k = 0; k < 10; k++) u_line.send_frame(8'($urandom()), 1'b1);
    join
    wait_rx_drained();
    wait_tx_idle();
    close_test("full duplex");

    $display("tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("run timed out after %0d ns with tests still running", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: uart_top.f
+incdir+.
uart_pkg.sv
uart_rx_sampler.sv
uart_rx_framer.sv
uart_tx_serializer.sv
uart_top.sv
tb_uart_line.sv
tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_top

sources:
  - include_dirs:
      - .
    files:
      - uart_pkg.sv
      - uart_rx_sampler.sv
      - uart_rx_framer.sv
      - uart_tx_serializer.sv
      - uart_top.sv
      - target: test
        files:
          - tb_uart_line.sv
          - tb_uart_top.sv
